//--- source/exec_settings.svh
// ------------------------------
// Sizing of the execute path
// EXEC_REG_COUNT must equal 2 ** EXEC_REG_BITS
// The instruction word stays 32 bits wide whatever the data width
// ------------------------------
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Width of one data word
`define EXEC_XLEN 32
// Architectural registers, r0 included
`define EXEC_REG_COUNT 16
// Bits needed to name one register
`define EXEC_REG_BITS 4

`endif

//--- source/exec_pkg.sv
// ------------------------------
// Shared types of the execute path
// Both instruction forms must add up to exactly 32 bits
// ------------------------------
`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]     data_word_t;
    typedef logic [`EXEC_REG_BITS-1:0] reg_index_t;

    // Operation codes, as found in bits 30 to 28 of both forms
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // ------------------------------
    // Instruction word
    // ------------------------------

    // Register-register form, form flag clear
    typedef struct packed {
        logic                           form;
        alu_op_e                        op;
        reg_index_t                     dest;
        reg_index_t                     src1;
        reg_index_t                     src2;
        logic [31-4-3*`EXEC_REG_BITS:0] unused;
    } exec_rr_t;

    // Register-immediate form, form flag set and a signed immediate in the low bits
    typedef struct packed {
        logic                           form;
        alu_op_e                        op;
        reg_index_t                     dest;
        reg_index_t                     src1;
        logic [31-4-2*`EXEC_REG_BITS:0] imm;
    } exec_ri_t;

    // The same word seen through either form, picked by bit 31
    typedef union packed {
        exec_rr_t rr;
        exec_ri_t ri;
    } exec_instr_u;

    // ------------------------------
    // Pipeline contents
    // ------------------------------

    // Decoded instruction held in the issue register
    // A set constant bit means the operand comes from constant_value and never from a register
    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        reg_index_t       dest;
        reg_index_t [1:0] src;
        logic [1:0]       constant;
        data_word_t [1:0] constant_value;
    } issue_bundle_t;

    // A result travelling through execute, commit and out of the unit
    typedef struct packed {
        logic       valid;
        reg_index_t dest;
        data_word_t data;
    } stage_result_t;

endpackage : exec_pkg

//--- source/register_file.sv
// ------------------------------
// Register file with two asynchronous read ports and one write port
// No internal write-to-read bypass, so a value written at an edge is seen after it
// ------------------------------
`timescale 1ns/100ps
`include "exec_settings.svh"

module register_file (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  exec_pkg::reg_index_t [1:0] read_index_i,
    output exec_pkg::data_word_t [1:0] read_data_o,
    input  exec_pkg::stage_result_t    write_i
);

    import exec_pkg::*;

    data_word_t registers [`EXEC_REG_COUNT];

    // All registers start at zero
    // Entry 0 is only ever touched by reset, so r0 reads zero forever
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
                registers[r] <= '0;
            end
        end else if (write_i.valid && (write_i.dest != '0)) begin
            registers[write_i.dest] <= write_i.data;
        end
    end

    // Both read ports are plain multiplexers on the index
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read_data_o[p] = registers[read_index_i[p]];
        end
    end

    // A write aimed at r0 must leave the stored zero untouched on the following cycle
    r0_write_ignored: assert property (@(posedge clk_i) disable iff (reset_i)
        write_i.valid && (write_i.dest == '0) |=> $stable(registers[0]));

endmodule : register_file

//--- source/issue_stage.sv
// ------------------------------
// Issue register, decode and hazard detection
// Accepts one instruction per cycle with no way to stall the source
// Operand 0 is always source one, operand 1 is source two or the immediate
// ------------------------------
`timescale 1ns/100ps

module issue_stage (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Incoming instruction strobe
    input  logic                       instr_valid_i,
    input  exec_pkg::exec_instr_u      instr_i,

    // Results held by the later stages
    input  exec_pkg::stage_result_t    execute_result_i,
    input  exec_pkg::stage_result_t    commit_result_i,

    // Register file read ports
    output exec_pkg::reg_index_t [1:0] read_index_o,
    input  exec_pkg::data_word_t [1:0] read_data_i,

    // Towards the bypass controller
    output exec_pkg::data_word_t [1:0] issue_operand_o,
    output logic [1:0]                 issue_immediate_o,
    output logic [1:0]                 execute_valid_o,
    output logic [1:0]                 commit_valid_o,

    // Towards the ALU
    output exec_pkg::issue_bundle_t    issue_o
);

    import exec_pkg::*;

    issue_bundle_t decoded;
    issue_bundle_t issue_q;

    // ------------------------------
    // Decode
    // ------------------------------

    // Operation, destination and source one sit in the same place in both forms
    always_comb begin
        decoded.valid          = instr_valid_i;
        decoded.op             = instr_i.rr.op;
        decoded.dest           = instr_i.rr.dest;
        decoded.src[0]         = instr_i.rr.src1;
        decoded.constant_value = '0;
        // Reading r0 is the same as feeding a constant zero
        decoded.constant[0]    = (instr_i.rr.src1 == '0);
        if (instr_i.rr.form) begin
            // Immediate form, operand 1 is the sign-extended immediate
            decoded.src[1]            = '0;
            decoded.constant[1]       = 1'b1;
            decoded.constant_value[1] = data_word_t'($signed(instr_i.ri.imm));
        end else begin
            decoded.src[1]            = instr_i.rr.src2;
            decoded.constant[1]       = (instr_i.rr.src2 == '0);
        end
    end

    // Only valid is cleared, the rest is don't-care while valid is low
    always_ff @(posedge clk_i) begin
        issue_q <= decoded;
        if (reset_i) begin
            issue_q.valid <= 1'b0;
        end
    end

    // ------------------------------
    // Operands and hazards
    // ------------------------------

    assign read_index_o      = issue_q.src;
    assign issue_immediate_o = issue_q.constant;
    assign issue_o           = issue_q;

    // The execute register holds the previous instruction, commit the one before it
    // A stage only counts when its valid bit is set
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            execute_valid_o[i] = execute_result_i.valid &&
                                 (execute_result_i.dest == issue_q.src[i]);
            commit_valid_o[i]  = commit_result_i.valid &&
                                 (commit_result_i.dest == issue_q.src[i]);
            // Constants bypass the register file entirely
            issue_operand_o[i] = issue_q.constant[i] ? issue_q.constant_value[i]
                                                     : read_data_i[i];
        end
    end

    // An accepted instruction must be fully defined
    instr_known: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> !$isunknown(instr_i));

endmodule : issue_stage

//--- source/bypass_controller.sv
// ------------------------------
// Operand forwarding in front of the ALU
// Newest data wins, execute over commit over the issued value
// Flagged constant operands are never forwarded
// ------------------------------
`timescale 1ns/100ps

module bypass_controller (
    // Operands read or built by the issue stage
    input  exec_pkg::data_word_t [1:0] issue_operand_i,
    input  logic [1:0]                 issue_immediate_i,

    // Execute register data and per-operand match
    input  exec_pkg::data_word_t [1:0] execute_data_i,
    input  logic [1:0]                 execute_valid_i,

    // Commit register data and per-operand match
    input  exec_pkg::data_word_t [1:0] commit_data_i,
    input  logic [1:0]                 commit_valid_i,

    // Operands handed to the ALU
    output exec_pkg::data_word_t [1:0] operand_o
);

    logic [1:0] take_execute;
    logic [1:0] take_commit;

    for (genvar i = 0; i < 2; i++) begin : g_operand

        // A constant cannot depend on an older instruction
        assign take_execute[i] = execute_valid_i[i] & ~issue_immediate_i[i];
        assign take_commit[i]  = commit_valid_i[i] & ~issue_immediate_i[i];

        always_comb begin : forward_mux
            casez ({take_execute[i], take_commit[i]})
                2'b1?:   operand_o[i] = execute_data_i[i];
                2'b01:   operand_o[i] = commit_data_i[i];
                default: operand_o[i] = issue_operand_i[i];
            endcase
        end : forward_mux

    end : g_operand

endmodule : bypass_controller

//--- source/alu_stage.sv
// ------------------------------
// ALU and execute register
// Shift amounts are the low log2(XLEN) bits of operand 1
// SLT compares as signed and returns 0 or 1
// ------------------------------
`timescale 1ns/100ps
`include "exec_settings.svh"

module alu_stage (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Decoded instruction and forwarded operands
    input  exec_pkg::issue_bundle_t    issue_i,
    input  exec_pkg::data_word_t [1:0] operand_i,

    // Execute register
    output exec_pkg::stage_result_t    execute_result_o
);

    import exec_pkg::*;

    localparam int SHIFT_BITS = $clog2(`EXEC_XLEN);

    logic [SHIFT_BITS-1:0] shift_amount;
    logic                  less_than;
    data_word_t            alu_result;
    stage_result_t         execute_q;

    // ------------------------------
    // Datapath
    // ------------------------------

    assign shift_amount = operand_i[1][SHIFT_BITS-1:0];

    // Signed compare for SLT
    assign less_than = $signed(operand_i[0]) < $signed(operand_i[1]);

    always_comb begin
        case (issue_i.op)
            ALU_ADD: alu_result = operand_i[0] + operand_i[1];
            ALU_SUB: alu_result = operand_i[0] - operand_i[1];
            ALU_AND: alu_result = operand_i[0] & operand_i[1];
            ALU_OR:  alu_result = operand_i[0] | operand_i[1];
            ALU_XOR: alu_result = operand_i[0] ^ operand_i[1];
            ALU_SLL: alu_result = operand_i[0] << shift_amount;
            // Logical shift, zeros come in from the top
            ALU_SRL: alu_result = operand_i[0] >> shift_amount;
            ALU_SLT: alu_result = data_word_t'(less_than);
            default: alu_result = '0;
        endcase
    end

    // ------------------------------
    // Execute register
    // ------------------------------

    // Bubbles pass through as invalid entries so distances stay counted in cycles
    always_ff @(posedge clk_i) begin
        execute_q.valid <= issue_i.valid;
        execute_q.dest  <= issue_i.dest;
        execute_q.data  <= alu_result;
        if (reset_i) begin
            execute_q.valid <= 1'b0;
        end
    end

    // Seen by the issue stage for matching and by the bypass for data
    assign execute_result_o = execute_q;

endmodule : alu_stage

//--- source/commit_stage.sv
// ------------------------------
// Commit register, write-back and unit output
// The output is valid one cycle after the execute result
// Results to r0 still leave the unit but are not written back
// ------------------------------
`timescale 1ns/100ps

module commit_stage (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // From the execute register
    input  exec_pkg::stage_result_t execute_result_i,

    // Commit register, used for forwarding
    output exec_pkg::stage_result_t commit_result_o,

    // Register file write port
    output exec_pkg::stage_result_t write_o,

    // Unit output
    output exec_pkg::stage_result_t result_o
);

    import exec_pkg::*;

    stage_result_t commit_q;

    // Valid is the only bit that needs a defined reset value
    always_ff @(posedge clk_i) begin
        commit_q <= execute_result_i;
        if (reset_i) begin
            commit_q.valid <= 1'b0;
        end
    end

    assign commit_result_o = commit_q;
    assign result_o        = commit_q;

    // Write-back lands at the next edge, the register file itself drops r0 writes
    assign write_o = commit_q;

    // Nothing may leave the unit straight after reset
    no_result_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !result_o.valid);

endmodule : commit_stage

//--- source/exec_unit_top.sv
// ------------------------------
// Three-stage execute unit
// One instruction per cycle, result three edges after acceptance
// No back-pressure on either side
// ------------------------------
`timescale 1ns/100ps

module exec_unit_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    instr_valid_i,
    input  exec_pkg::exec_instr_u   instr_i,
    output exec_pkg::stage_result_t result_o
);

    import exec_pkg::*;

    // ------------------------------
    // Inter-stage wires
    // ------------------------------

    reg_index_t [1:0] read_index;
    data_word_t [1:0] read_data;
    data_word_t [1:0] issue_operand;
    data_word_t [1:0] operand;
    logic [1:0]       issue_immediate;
    logic [1:0]       execute_valid;
    logic [1:0]       commit_valid;
    issue_bundle_t    issue;
    stage_result_t    execute_result;
    stage_result_t    commit_result;
    stage_result_t    write_port;

    // Input side
    issue_stage u_issue (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .execute_result_i  (execute_result),
        .commit_result_i   (commit_result),
        .read_index_o      (read_index),
        .read_data_i       (read_data),
        .issue_operand_o   (issue_operand),
        .issue_immediate_o (issue_immediate),
        .execute_valid_o   (execute_valid),
        .commit_valid_o    (commit_valid),
        .issue_o           (issue)
    );

    register_file u_regs (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .read_index_i (read_index),
        .read_data_o  (read_data),
        .write_i      (write_port)
    );

    // Processing part, both operands see the same stage data
    bypass_controller u_bypass (
        .issue_operand_i   (issue_operand),
        .issue_immediate_i (issue_immediate),
        .execute_data_i    ({2{execute_result.data}}),
        .execute_valid_i   (execute_valid),
        .commit_data_i     ({2{commit_result.data}}),
        .commit_valid_i    (commit_valid),
        .operand_o         (operand)
    );

    alu_stage u_alu (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .issue_i          (issue),
        .operand_i        (operand),
        .execute_result_o (execute_result)
    );

    // Output side
    commit_stage u_commit (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .execute_result_i (execute_result),
        .commit_result_o  (commit_result),
        .write_o          (write_port),
        .result_o         (result_o)
    );

endmodule : exec_unit_top

//--- test/exec_checker.sv
// ------------------------------
// Reference model and result checker
// Expects every accepted instruction at the output three edges later
// Any valid output with nothing due counts as an error
// ------------------------------
`timescale 1ns/100ps
`include "exec_settings.svh"

module exec_checker (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    instr_valid_i,
    input  exec_pkg::exec_instr_u   instr_i,
    input  exec_pkg::stage_result_t result_i,
    output int                      checked_count_o,
    output int                      error_count_o
);

    import exec_pkg::*;

    localparam int LATENCY = 3;

    // One expected result and the cycle it is due in
    typedef struct packed {
        logic [31:0] due;
        reg_index_t  dest;
        data_word_t  data;
    } expected_t;

    expected_t   pending[$];
    expected_t   entry;
    data_word_t  model_regs [`EXEC_REG_COUNT];
    data_word_t  operand_a;
    data_word_t  operand_b;
    logic [31:0] cycle;

    // Operation rules, shift amount from the low five bits of the second operand
    function automatic data_word_t compute(input alu_op_e op, input data_word_t a,
                                           input data_word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? data_word_t'(1) : '0;
            default: return '0;
        endcase
    endfunction

    always @(posedge clk_i) begin
        if (reset_i) begin
            pending.delete();
            cycle           = 0;
            checked_count_o = 0;
            error_count_o   = 0;
            for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
                model_regs[r] = '0;
            end
        end else begin
            cycle = cycle + 1;
            // The output seen here was registered at the previous edge
            if ((pending.size() > 0) && (pending[0].due == cycle)) begin
                entry = pending.pop_front();
                checked_count_o++;
                if (result_i.valid !== 1'b1) begin
                    $display("Error at %0t: result_o.valid expected 1, got %b", $time,
                             result_i.valid);
                    error_count_o++;
                end else begin
                    if (result_i.dest !== entry.dest) begin
                        $display("Error at %0t: result_o.dest expected %0d, got %0d",
                                 $time, entry.dest, result_i.dest);
                        error_count_o++;
                    end
                    if (result_i.data !== entry.data) begin
                        $display("Error at %0t: result_o.data expected %h, got %h",
                                 $time, entry.data, result_i.data);
                        error_count_o++;
                    end
                end
            end else if (result_i.valid !== 1'b0) begin
                $display("Error at %0t: result_o.valid expected 0, got %b", $time,
                         result_i.valid);
                error_count_o++;
            end
            // Architectural state moves in issue order, r0 entry never changes
            if (instr_valid_i === 1'b1) begin
                operand_a = model_regs[instr_i.rr.src1];
                if (instr_i.rr.form) begin
                    operand_b = {{(`EXEC_XLEN - 20){instr_i.ri.imm[19]}}, instr_i.ri.imm};
                end else begin
                    operand_b = model_regs[instr_i.rr.src2];
                end
                entry.due  = cycle + LATENCY;
                entry.dest = instr_i.rr.dest;
                entry.data = compute(instr_i.rr.op, operand_a, operand_b);
                pending.push_back(entry);
                if (instr_i.rr.dest != '0) begin
                    model_regs[instr_i.rr.dest] = entry.data;
                end
            end
        end
    end

endmodule : exec_checker

//--- test/exec_tb.sv
// ------------------------------
// Testbench for the execute unit
// Random instructions from a fixed-seed LFSR, driven on the falling edge
// Indices lean towards r0 to r3 so that hazards come often
// ------------------------------
`timescale 1ns/100ps

module exec_tb;

    import exec_pkg::*;

    localparam int CLOCK_PERIOD  = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int TEST_CYCLES   = 2000;
    localparam int MARGIN_CYCLES = 50;

    logic          clk;
    logic          reset;
    logic          instr_valid;
    exec_instr_u   instr;
    stage_result_t result;
    logic [31:0]   lfsr_state;
    int            checked_count;
    int            error_count;

    exec_unit_top u_dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .result_o      (result)
    );

    // Reference model and comparison live in their own module
    exec_checker u_checker (
        .clk_i           (clk),
        .reset_i         (reset),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .result_i        (result),
        .checked_count_o (checked_count),
        .error_count_o   (error_count)
    );

    // ------------------------------
    // Random source
    // ------------------------------

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step for every bit collected
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Six times in eight the index comes from r0 to r3, otherwise from the whole file
    task automatic pick_register(output reg_index_t index);
        logic [31:0] bits;
        take_bits(3, bits);
        if (bits < 6) begin
            take_bits(2, bits);
        end else begin
            take_bits(4, bits);
        end
        index = reg_index_t'(bits);
    endtask

    // Builds the next input word, one cycle in eight is a bubble
    task automatic drive_next;
        logic [31:0] bits;
        exec_instr_u word;
        take_bits(3, bits);
        instr_valid = (bits[2:0] != 3'b000);
        // The immediate field covers source two and the unused bits of the other form
        take_bits(20, bits);
        word.ri.imm = bits[19:0];
        take_bits(1, bits);
        word.rr.form = bits[0];
        take_bits(3, bits);
        word.rr.op = alu_op_e'(bits[2:0]);
        pick_register(word.rr.dest);
        pick_register(word.rr.src1);
        if (!word.rr.form) begin
            pick_register(word.rr.src2);
        end
        instr = word;
    endtask

    // ------------------------------
    // Clock, stimulus and watchdog
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        lfsr_state  = 32'h97fb4d32;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < TEST_CYCLES; n++) begin
            drive_next();
            @(negedge clk);
        end
        // Let the last results drain out of the pipeline
        instr_valid = 1'b0;
        repeat (4) @(negedge clk);
        $display("Closing summary: %0d results checked, %0d errors", checked_count,
                 error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Fires only if the sequence above overruns its own length by the margin
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

endmodule : exec_tb

//--- src.f
+incdir+source
source/exec_pkg.sv
source/register_file.sv
source/issue_stage.sv
source/bypass_controller.sv
source/alu_stage.sv
source/commit_stage.sv
source/exec_unit_top.sv
test/exec_checker.sv
test/exec_tb.sv
